// ==== source/core_pkg.sv ====
package core_pkg;

    localparam int data_w = 32;

    // tag 0 is reserved, so the rob has 15 live tags
    localparam int rob_id_w = 4;

    typedef logic [data_w-1:0] data_t;
    typedef logic [rob_id_w-1:0] rob_id_t;

    // operand already holds its value
    localparam rob_id_t no_rob = '0;

    // one result broadcast
    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
        data_t   value;
    } cdb_t;

endpackage

// ==== source/lsq_pkg.sv ====
package lsq_pkg;

    localparam int lsb_size = 8;
    localparam int lsb_idx_w = 3;
    localparam int lsb_cnt_w = 4;

    // full rises this many slots early
    localparam int full_margin = 2;

    localparam int mem_words = 64;
    localparam int mem_addr_w = $clog2(mem_words);

    typedef logic [lsb_idx_w-1:0] lsb_idx_t;
    typedef logic [lsb_cnt_w-1:0] lsb_cnt_t;

    // loads first, so op <= op_lhu means load
    typedef enum logic [2:0] {
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw
    } mem_op_e;

    typedef struct packed {
        mem_op_e           op;
        core_pkg::data_t   v1;
        core_pkg::rob_id_t q1;
        core_pkg::data_t   v2;
        core_pkg::rob_id_t q2;
        core_pkg::data_t   imm;
        core_pkg::rob_id_t rob_id;
    } dispatch_t;

    typedef struct packed {
        logic              busy;
        logic              committed;
        mem_op_e           op;
        core_pkg::data_t   v1;
        core_pkg::rob_id_t q1;
        core_pkg::data_t   v2;
        core_pkg::rob_id_t q2;
        core_pkg::data_t   imm;
        core_pkg::rob_id_t rob_id;
    } lsb_entry_t;

    typedef struct packed {
        mem_op_e           op;
        core_pkg::data_t   addr;
        core_pkg::data_t   data;
        core_pkg::rob_id_t rob_id;
    } mem_req_t;

endpackage

// ==== source/lsb_dispatch.sv ====
`timescale 1ns/1ps

module lsb_dispatch (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         disp_valid,
    input  lsq_pkg::dispatch_t           disp,
    input  core_pkg::cdb_t               rs_cdb1,
    input  core_pkg::cdb_t               rs_cdb2,
    input  core_pkg::cdb_t               ls_cdb,
    input  logic                         issue_fire,
    input  logic                         rollback,
    input  lsq_pkg::lsb_idx_t            rollback_tail,
    input  lsq_pkg::lsb_cnt_t            rollback_count,
    output logic [lsq_pkg::lsb_size-1:0] alloc_en,
    output lsq_pkg::lsb_entry_t          new_entry,
    output logic                         full
);
    import core_pkg::*;
    import lsq_pkg::*;

    lsb_idx_t tail;
    lsb_cnt_t count;
    logic     write;
    cdb_t     buses [3];

    assign buses[0] = rs_cdb1;
    assign buses[1] = rs_cdb2;
    assign buses[2] = ls_cdb;

    // rollback wins over a stray dispatch
    assign write = disp_valid && !rollback;

    always_comb begin
        alloc_en = '0;
        alloc_en[tail] = write;
    end

    // results broadcast in the dispatch cycle never reach the slot
    always_comb begin
        new_entry.busy = 1'b1;
        new_entry.committed = 1'b0;
        new_entry.op = disp.op;
        new_entry.imm = disp.imm;
        new_entry.rob_id = disp.rob_id;
        new_entry.v1 = disp.v1;
        new_entry.q1 = disp.q1;
        new_entry.v2 = disp.v2;
        new_entry.q2 = disp.q2;
        for (int b = 0; b < 3; b++) begin
            if (buses[b].valid && disp.q1 != no_rob && buses[b].rob_id == disp.q1) begin
                new_entry.v1 = buses[b].value;
                new_entry.q1 = no_rob;
            end
            if (buses[b].valid && disp.q2 != no_rob && buses[b].rob_id == disp.q2) begin
                new_entry.v2 = buses[b].value;
                new_entry.q2 = no_rob;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tail <= '0;
            count <= '0;
        end else if (rollback) begin
            tail <= rollback_tail;
            count <= rollback_count;
        end else begin
            if (write) begin
                tail <= tail + 1'b1;
            end
            case ({write, issue_fire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full = count >= lsb_cnt_t'(lsb_size - full_margin);

endmodule

// ==== source/lsb_slot.sv ====
`timescale 1ns/1ps

module lsb_slot (
    input  logic                clk,
    input  logic                reset,
    input  logic                alloc,
    input  lsq_pkg::lsb_entry_t new_entry,
    input  logic                clear,
    input  core_pkg::cdb_t      rs_cdb1,
    input  core_pkg::cdb_t      rs_cdb2,
    input  core_pkg::cdb_t      ls_cdb,
    input  logic                commit_valid,
    input  core_pkg::rob_id_t   commit_rob_id,
    output lsq_pkg::lsb_entry_t entry
);
    import core_pkg::*;

    cdb_t buses [3];
    logic wait1;
    logic wait2;

    assign buses[0] = rs_cdb1;
    assign buses[1] = rs_cdb2;
    assign buses[2] = ls_cdb;

    assign wait1 = entry.q1 != no_rob;
    assign wait2 = entry.q2 != no_rob;

    always_ff @(posedge clk) begin
        if (reset) begin
            entry.busy <= 1'b0;
            entry.committed <= 1'b0;
        end else if (alloc) begin
            entry <= new_entry;
        end else if (clear) begin
            // issued, or thrown away by rollback
            entry.busy <= 1'b0;
            entry.committed <= 1'b0;
        end else if (entry.busy) begin
            // wakeup from any of the three buses
            for (int b = 0; b < 3; b++) begin
                if (wait1 && buses[b].valid && buses[b].rob_id == entry.q1) begin
                    entry.v1 <= buses[b].value;
                    entry.q1 <= no_rob;
                end
                if (wait2 && buses[b].valid && buses[b].rob_id == entry.q2) begin
                    entry.v2 <= buses[b].value;
                    entry.q2 <= no_rob;
                end
            end
            if (commit_valid && commit_rob_id == entry.rob_id) begin
                entry.committed <= 1'b1;
            end
        end
    end

endmodule

// ==== source/lsb_issue.sv ====
`timescale 1ns/1ps

module lsb_issue (
    input  logic                         clk,
    input  logic                         reset,
    input  lsq_pkg::lsb_entry_t          entries [lsq_pkg::lsb_size],
    input  logic                         mem_busy,
    input  logic                         rollback,
    output logic [lsq_pkg::lsb_size-1:0] clear,
    output logic                         issue_fire,
    output logic                         req_valid,
    output lsq_pkg::mem_req_t            req,
    output lsq_pkg::lsb_idx_t            rollback_tail,
    output lsq_pkg::lsb_cnt_t            rollback_count
);
    import core_pkg::*;
    import lsq_pkg::*;

    lsb_idx_t            head;
    lsb_entry_t          head_entry;
    logic                head_is_load;
    logic                head_ready;
    logic                store_found;
    lsb_idx_t            store_off;
    logic [lsb_size-1:0] discard;

    assign head_entry = entries[head];
    assign head_is_load = head_entry.op <= op_lhu;

    // stores wait for the rob commit, loads go once operands arrive
    assign head_ready = head_entry.busy
                        && head_entry.q1 == no_rob
                        && head_entry.q2 == no_rob
                        && (head_is_load || head_entry.committed);

    assign issue_fire = head_ready && !mem_busy && !rollback;

    // youngest committed store counted from head
    always_comb begin
        lsb_idx_t idx;
        store_found = 1'b0;
        store_off = '0;
        for (int k = 0; k < lsb_size; k++) begin
            idx = head + lsb_idx_t'(k);
            if (entries[idx].busy && entries[idx].committed && entries[idx].op >= op_sb) begin
                store_found = 1'b1;
                store_off = lsb_idx_t'(k);
            end
        end
    end

    // committed stores survive a rollback and still drain
    always_comb begin
        for (int i = 0; i < lsb_size; i++) begin
            discard[i] = entries[i].busy
                         && !(entries[i].committed && entries[i].op >= op_sb);
        end
    end

    assign rollback_tail = store_found ? head + store_off + 1'b1 : head;
    assign rollback_count = store_found ? lsb_cnt_t'(store_off) + 1'b1 : '0;

    always_comb begin
        clear = rollback ? discard : '0;
        if (issue_fire) begin
            clear[head] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= issue_fire;
            if (issue_fire) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            req.op <= head_entry.op;
            req.addr <= head_entry.v1 + head_entry.imm;
            req.data <= head_entry.v2;
            req.rob_id <= head_entry.rob_id;
        end
    end

endmodule

// ==== source/mem_unit.sv ====
`timescale 1ns/1ps

module mem_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  lsq_pkg::mem_req_t req,
    output logic              mem_busy,
    output core_pkg::cdb_t    ls_cdb
);
    import core_pkg::*;
    import lsq_pkg::*;

    data_t                 ram [mem_words];
    logic [mem_addr_w-1:0] word_idx;
    logic [1:0]            offset;
    logic                  is_load;
    data_t                 rword;
    logic [7:0]            rbyte;
    logic [15:0]           rhalf;
    data_t                 load_val;
    data_t                 wdata;
    logic [3:0]            wmask;

    assign word_idx = req.addr[mem_addr_w+1:2];
    assign offset = req.addr[1:0];
    assign is_load = req.op <= op_lhu;
    assign rword = ram[word_idx];
    assign rbyte = rword[8*offset +: 8];
    assign rhalf = offset[1] ? rword[31:16] : rword[15:0];

    always_comb begin
        case (req.op)
            op_lb: load_val = {{24{rbyte[7]}}, rbyte};
            op_lh: load_val = {{16{rhalf[15]}}, rhalf};
            op_lbu: load_val = {24'b0, rbyte};
            op_lhu: load_val = {16'b0, rhalf};
            default: load_val = rword;
        endcase
    end

    // replicate store data across lanes, enable only the addressed ones
    always_comb begin
        case (req.op)
            op_sb: begin
                wdata = {4{req.data[7:0]}};
                wmask = 4'b0001 << offset;
            end
            op_sh: begin
                wdata = {2{req.data[15:0]}};
                wmask = offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata = req.data;
                wmask = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_busy <= 1'b0;
            ls_cdb <= '0;
            for (int i = 0; i < mem_words; i++) begin
                ram[i] <= '0;
            end
        end else begin
            mem_busy <= req_valid;
            ls_cdb.valid <= req_valid;
            ls_cdb.rob_id <= req.rob_id;
            // stores report completion with value 0
            ls_cdb.value <= is_load ? load_val : '0;
            if (req_valid && !is_load) begin
                for (int b = 0; b < 4; b++) begin
                    if (wmask[b]) begin
                        ram[word_idx][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

// ==== source/lsb_top.sv ====
`timescale 1ns/1ps

module lsb_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               disp_valid,
    input  lsq_pkg::dispatch_t disp,
    input  core_pkg::cdb_t     rs_cdb1,
    input  core_pkg::cdb_t     rs_cdb2,
    input  logic               commit_valid,
    input  core_pkg::rob_id_t  commit_rob_id,
    input  logic               rollback,
    output logic               full,
    output core_pkg::cdb_t     ls_cdb
);
    import lsq_pkg::*;

    logic [lsb_size-1:0] alloc_en;
    logic [lsb_size-1:0] clear;
    lsb_entry_t          new_entry;
    lsb_entry_t          entries [lsb_size];
    logic                issue_fire;
    logic                req_valid;
    mem_req_t            req;
    logic                mem_busy;
    lsb_idx_t            rollback_tail;
    lsb_cnt_t            rollback_count;

    lsb_dispatch u_dispatch (
        .clk(clk),
        .reset(reset),
        .disp_valid(disp_valid),
        .disp(disp),
        .rs_cdb1(rs_cdb1),
        .rs_cdb2(rs_cdb2),
        .ls_cdb(ls_cdb),
        .issue_fire(issue_fire),
        .rollback(rollback),
        .rollback_tail(rollback_tail),
        .rollback_count(rollback_count),
        .alloc_en(alloc_en),
        .new_entry(new_entry),
        .full(full)
    );

    for (genvar i = 0; i < lsb_size; i++) begin : g_slot
        lsb_slot u_slot (
            .clk(clk),
            .reset(reset),
            .alloc(alloc_en[i]),
            .new_entry(new_entry),
            .clear(clear[i]),
            .rs_cdb1(rs_cdb1),
            .rs_cdb2(rs_cdb2),
            .ls_cdb(ls_cdb),
            .commit_valid(commit_valid),
            .commit_rob_id(commit_rob_id),
            .entry(entries[i])
        );
    end

    lsb_issue u_issue (
        .clk(clk),
        .reset(reset),
        .entries(entries),
        .mem_busy(mem_busy),
        .rollback(rollback),
        .clear(clear),
        .issue_fire(issue_fire),
        .req_valid(req_valid),
        .req(req),
        .rollback_tail(rollback_tail),
        .rollback_count(rollback_count)
    );

    mem_unit u_mem (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req(req),
        .mem_busy(mem_busy),
        .ls_cdb(ls_cdb)
    );

endmodule

// ==== tests/lsb_tb.sv ====
`timescale 1ns/1ps

module lsb_tb;
    import core_pkg::*;
    import lsq_pkg::*;

    logic      clk;
    logic      reset;
    logic      disp_valid;
    dispatch_t disp;
    cdb_t      rs_cdb1;
    cdb_t      rs_cdb2;
    logic      commit_valid;
    rob_id_t   commit_rob_id;
    logic      rollback;
    logic      full;
    cdb_t      ls_cdb;

    // reference memory and the last dispatch seen for each tag
    data_t   ref_mem [mem_words];
    mem_op_e tag_op [16];
    data_t   tag_v1 [16];
    data_t   tag_v2 [16];
    data_t   tag_imm [16];
    rob_id_t tag_q1 [16];
    rob_id_t tag_q2 [16];

    cdb_t results [$];

    lsb_top uut (
        .clk(clk),
        .reset(reset),
        .disp_valid(disp_valid),
        .disp(disp),
        .rs_cdb1(rs_cdb1),
        .rs_cdb2(rs_cdb2),
        .commit_valid(commit_valid),
        .commit_rob_id(commit_rob_id),
        .rollback(rollback),
        .full(full),
        .ls_cdb(ls_cdb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic value_error(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_cdb(input cdb_t actual, input cdb_t expected);
        if (actual !== expected) begin
            value_error($sformatf("ls_cdb tag %0d value %h, expected tag %0d value %h",
                actual.rob_id, actual.value, expected.rob_id, expected.value));
        end
    endtask

    task automatic check_full(input logic actual, input logic expected);
        if (actual !== expected) begin
            value_error($sformatf("full is %b, expected %b", actual, expected));
        end
    endtask

    task automatic drive_idle();
        disp_valid = 1'b0;
        disp = '0;
        rs_cdb1 = '0;
        rs_cdb2 = '0;
        commit_valid = 1'b0;
        commit_rob_id = no_rob;
        rollback = 1'b0;
    endtask

    // advance to the next falling edge and collect any reported result
    task automatic next_cycle();
        @(negedge clk);
        if (!reset && ls_cdb.valid) begin
            results.push_back(ls_cdb);
        end
        drive_idle();
    endtask

    task automatic step_cycles(input int n);
        repeat (n) begin
            next_cycle();
        end
    endtask

    function automatic mem_op_e op_from_name(input logic [63:0] name);
        case (name)
            "lb": return op_lb;
            "lh": return op_lh;
            "lw": return op_lw;
            "lbu": return op_lbu;
            "lhu": return op_lhu;
            "sb": return op_sb;
            "sh": return op_sh;
            default: return op_sw;
        endcase
    endfunction

    // byte and half-word lanes picked by the low address bits
    function automatic data_t model_load(input mem_op_e op, input data_t addr);
        data_t       word;
        logic [7:0]  b;
        logic [15:0] h;
        word = ref_mem[addr[7:2]];
        b = word >> (8 * addr[1:0]);
        h = addr[1] ? word[31:16] : word[15:0];
        case (op)
            op_lb: return {{24{b[7]}}, b};
            op_lbu: return {24'h0, b};
            op_lh: return {{16{h[15]}}, h};
            op_lhu: return {16'h0, h};
            default: return word;
        endcase
    endfunction

    task automatic model_store(input mem_op_e op, input data_t addr, input data_t data);
        if (op == op_sb) begin
            ref_mem[addr[7:2]][8*addr[1:0] +: 8] = data[7:0];
        end else if (op == op_sh) begin
            ref_mem[addr[7:2]][16*addr[1] +: 16] = data[15:0];
        end else begin
            ref_mem[addr[7:2]] = data;
        end
    endtask

    task automatic model_wakeup(input rob_id_t tag, input data_t value);
        for (int t = 0; t < 16; t++) begin
            if (tag_q1[t] == tag) begin
                tag_v1[t] = value;
                tag_q1[t] = no_rob;
            end
            if (tag_q2[t] == tag) begin
                tag_v2[t] = value;
                tag_q2[t] = no_rob;
            end
        end
    endtask

    task automatic expect_result(input rob_id_t tag, input data_t value);
        int    i;
        data_t model;
        data_t addr;
        cdb_t  got;
        for (i = 0; i < 50 && results.size() == 0; i++) begin
            next_cycle();
        end
        if (results.size() == 0) begin
            abort_run($sformatf("timeout waiting for the result of tag %0d", tag));
        end
        if (tag_q1[tag] != no_rob || tag_q2[tag] != no_rob) begin
            abort_run($sformatf("reference model has tag %0d still waiting", tag));
        end
        addr = tag_v1[tag] + tag_imm[tag];
        if (tag_op[tag] <= op_lhu) begin
            model = model_load(tag_op[tag], addr);
        end else begin
            model_store(tag_op[tag], addr, tag_v2[tag]);
            model = '0;
        end
        if (model !== value) begin
            abort_run($sformatf("stimulus expects %h for tag %0d, reference gives %h",
                value, tag, model));
        end
        got = results.pop_front();
        check_cdb(got, '{valid: 1'b1, rob_id: tag, value: value});
        model_wakeup(tag, value);
    endtask

    // no result may be left over once the bus goes quiet
    task automatic wait_idle();
        int i;
        for (i = 0; i < 50 && ls_cdb.valid; i++) begin
            next_cycle();
        end
        if (ls_cdb.valid) begin
            abort_run("timeout waiting for ls_cdb to go idle");
        end
        if (results.size() != 0) begin
            value_error($sformatf("unexpected ls_cdb report for tag %0d",
                results[0].rob_id));
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [63:0] name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] f;
        reset = 1'b1;
        drive_idle();
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i] = '0;
        end
        for (int t = 0; t < 16; t++) begin
            tag_q1[t] = no_rob;
            tag_q2[t] = no_rob;
        end
        fd = $fopen("tests/lsb_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tests/lsb_stim.txt");
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            kind = 8'h0;
            if (n > 0) begin
                n = $sscanf(line, "%c", kind);
            end
            case (kind)
                "D": begin
                    n = $sscanf(line, "D %s %h %h %h %h %h %h", name, a, b, c, d, e, f);
                    disp_valid = 1'b1;
                    disp = '{op: op_from_name(name), v1: a, q1: b[3:0], v2: c,
                             q2: d[3:0], imm: e, rob_id: f[3:0]};
                    tag_op[f[3:0]] = op_from_name(name);
                    tag_v1[f[3:0]] = a;
                    tag_q1[f[3:0]] = b[3:0];
                    tag_v2[f[3:0]] = c;
                    tag_q2[f[3:0]] = d[3:0];
                    tag_imm[f[3:0]] = e;
                end
                "B": begin
                    n = $sscanf(line, "B %d %h %h", a, b, c);
                    if (a == 1) begin
                        rs_cdb1 = '{valid: 1'b1, rob_id: b[3:0], value: c};
                    end else begin
                        rs_cdb2 = '{valid: 1'b1, rob_id: b[3:0], value: c};
                    end
                    model_wakeup(b[3:0], c);
                end
                "C": begin
                    n = $sscanf(line, "C %h", a);
                    commit_valid = 1'b1;
                    commit_rob_id = a[3:0];
                end
                "R": rollback = 1'b1;
                "N": begin
                    n = $sscanf(line, "N %d", a);
                    step_cycles(a);
                end
                "E": begin
                    n = $sscanf(line, "E %h %h", a, b);
                    expect_result(a[3:0], b);
                end
                "F": begin
                    n = $sscanf(line, "F %d", a);
                    check_full(full, a[0]);
                end
                "W": wait_idle();
                default: ;
            endcase
        end
        $fclose(fd);
        wait_idle();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== tests/lsb_stim.txt ====
# D op v1 q1 v2 q2 imm tag | B bus tag value | C tag | R | N cycles
# E tag value (expected ls_cdb) | F full | W wait for idle bus, nothing pending
D sw 0 0 8badf00d 0 10 1
N 1
D sb 0 0 7e 0 12 2
N 1
D sh 0 0 c3d2 0 16 3
N 1
C 1
N 1
C 2
N 1
C 3
N 1
E 1 0
E 2 0
E 3 0
D lw 0 0 0 0 10 4
N 1
D lb 0 0 0 0 13 5
N 1
D lbu 0 0 0 0 13 6
N 1
D lh 0 0 0 0 16 7
N 1
D lhu 0 0 0 0 16 8
N 1
D lb 0 0 0 0 12 9
N 1
D lh 0 0 0 0 10 a
N 1
E 4 8b7ef00d
E 5 ffffff8b
E 6 0000008b
E 7 ffffc3d2
E 8 0000c3d2
E 9 0000007e
E a fffff00d
W
D lw 0 b 0 0 8 c
N 5
W
B 1 b 8
N 1
E c 8b7ef00d
W
D lw 0 d 0 0 10 e
B 2 d 4
N 1
E e c3d20000
W
D sw 0 0 12345678 0 20 1
N 1
D lw 0 0 0 0 20 2
N 6
W
C 1
N 1
E 1 0
E 2 12345678
W
D lw 0 f 0 0 0 3
N 1
D lbu 0 0 0 0 20 4
N 1
D lhu 0 0 0 0 22 5
N 1
D lb 0 0 0 0 21 6
N 1
D lh 0 0 0 0 20 7
N 1
F 0
D lw 0 0 0 0 24 8
N 1
F 1
B 1 f 20
N 1
E 3 12345678
E 4 00000078
E 5 00001234
E 6 00000056
E 7 00005678
E 8 00000000
F 0
W
D sw 0 0 0 e 30 1
N 1
C 1
D sb 0 0 ff 0 31 2
N 1
D lw 0 0 0 0 30 3
N 1
R
N 4
W
B 1 e cafebabe
N 1
E 1 0
N 5
W
D lw 0 0 0 0 30 4
N 1
E 4 cafebabe
W

// ==== build.f ====
source/core_pkg.sv
source/lsq_pkg.sv
source/lsb_dispatch.sv
source/lsb_slot.sv
source/lsb_issue.sv
source/mem_unit.sv
source/lsb_top.sv
tests/lsb_tb.sv
